// ==== hw/debug_pkg.sv ====
// debug unit shared definitions
`default_nettype none

package debug_pkg;

   // frame layout, MSB first: opcode | valid | request type | data
   localparam int NB_FRAME    = 32;
   localparam int NB_OPCODE   = 6;
   localparam int NB_REQ_TYPE = 9;
   localparam int NB_DATA     = 16;
   localparam int VALID_POS   = NB_DATA + NB_REQ_TYPE;

   localparam int NB_SELECT   = 6;
   localparam int NB_WE       = 4;
   localparam int NB_REG_NUM  = 5;

   typedef logic [NB_FRAME-1:0]  frame_t;
   typedef logic [NB_SELECT-1:0] select_t;
   typedef logic [NB_WE-1:0]     we_t;

   // host commands
   typedef enum logic [NB_OPCODE-1:0] {
      START          = 6'b000001,
      RESET          = 6'b000010,
      REQ_DATA       = 6'b000011,
      LOAD_INSTR_LSB = 6'b000100,
      LOAD_INSTR_MSB = 6'b000101,
      MODE_GET       = 6'b001000,
      MODE_SET_CONT  = 6'b001001,
      MODE_SET_STEP  = 6'b001010,
      STEP           = 6'b100000,
      GOT_DATA       = 6'b100100,
      GIB_DATA       = 6'b100101
   } opcode_e;

   // what the core should stream back
   typedef enum logic [NB_REQ_TYPE-1:0] {
      REQ_MEM_DATA         = 9'b000000001,
      REQ_MEM_INSTR        = 9'b000000010,
      REQ_REG              = 9'b000000100,
      REQ_REG_PC           = 9'b000000101,
      REQ_LATCH_FETCH_DATA = 9'b000001000,
      REQ_LATCH_FETCH_CTRL = 9'b000001001,
      REQ_LATCH_DECO_DATA  = 9'b000010000,
      REQ_LATCH_DECO_CTRL  = 9'b000010001,
      REQ_LATCH_EXEC_DATA  = 9'b000100000,
      REQ_LATCH_EXEC_CTRL  = 9'b000100001,
      REQ_LATCH_MEM_DATA   = 9'b001000000,
      REQ_LATCH_MEM_CTRL   = 9'b001000001
   } req_type_e;

   // select codes seen by the core, registers use 0 + reg number
   localparam select_t SEL_NONE           = 6'b111111;
   localparam select_t SEL_MEM_DATA       = 6'b100000;
   localparam select_t SEL_MEM_INSTR      = 6'b100001;
   localparam select_t SEL_PC             = 6'b100010;
   localparam select_t SEL_FETCH_DATA     = 6'b100100;
   localparam select_t SEL_FETCH_CTRL     = 6'b100101;
   localparam select_t SEL_DECO_DATA      = 6'b100110;
   localparam select_t SEL_DECO_CTRL      = 6'b100111;
   localparam select_t SEL_EXEC_DATA      = 6'b101000;
   localparam select_t SEL_EXEC_CTRL      = 6'b101001;
   localparam select_t SEL_MEM_LATCH_DATA = 6'b101010;
   localparam select_t SEL_MEM_LATCH_CTRL = 6'b101011;

   // instruction memory byte enables
   localparam we_t WE_NONE = 4'b0000;
   localparam we_t WE_LSB  = 4'b0011;
   localparam we_t WE_MSB  = 4'b1100;

   // replies to the host
   localparam frame_t REPLY_OK        = {6'b000011, 26'd0};
   localparam frame_t REPLY_NOK       = {6'b000010, 26'd0};
   localparam frame_t REPLY_EOP       = {6'b000100, 26'd0};
   localparam frame_t REPLY_IDLE      = '1;
   localparam frame_t REPLY_MODE_CONT = {MODE_SET_CONT, 26'd0};
   localparam frame_t REPLY_MODE_STEP = {MODE_SET_STEP, 26'd0};

   // capture buffer
   localparam int BUFFER_WORDS = 3;
   localparam int NB_COUNT     = 2;

endpackage

`default_nettype wire

// ==== hw/debug_if.sv ====
// debug unit internal buses
`default_nettype none

// decoded command, shared by buffer and framer
interface debug_cmd_if;

   logic                strobe;
   debug_pkg::opcode_e  opcode;
   logic                step_mode;

   modport source (
      output strobe,
      output opcode,
      output step_mode
   );

   modport sink (
      input strobe,
      input opcode,
      input step_mode
   );

endinterface

// capture buffer state toward the framer
interface capture_if;

   debug_pkg::frame_t                   word;
   logic                                has_word;
   logic                                capturing;
   logic [debug_pkg::NB_COUNT-1:0]      count;

   modport source (
      output word,
      output has_word,
      output capturing,
      output count
   );

   modport sink (
      input word,
      input has_word,
      input capturing,
      input count
   );

endinterface

`default_nettype wire

// ==== hw/debug_command_decoder.sv ====
// host command decoder
`default_nettype none

module debug_command_decoder (
   input  wire                                 i_clock,
   input  wire                                 i_reset,
   input  wire debug_pkg::frame_t              i_frame_from_host,
   debug_cmd_if.source                         cmd,
   output logic                                o_mips_reset,
   output logic                                o_mips_valid,
   output logic [debug_pkg::NB_FRAME-1:0]      o_instr_data,
   output logic [debug_pkg::NB_DATA-1:0]       o_instr_addr,
   output debug_pkg::we_t                      o_instr_mem_we,
   output logic [debug_pkg::NB_DATA-1:0]       o_mem_addr,
   output debug_pkg::select_t                  o_request_select
);

   debug_pkg::opcode_e                    opcode;
   debug_pkg::req_type_e                  req_type;
   logic [debug_pkg::NB_DATA-1:0]         data;
   logic                                  valid;
   logic                                  valid_d;
   logic                                  strobe;
   logic                                  run;
   logic                                  step_mode;
   debug_pkg::select_t                    type_select;

   // frame fields
   assign opcode = debug_pkg::opcode_e'(
      i_frame_from_host[debug_pkg::NB_FRAME-1 -: debug_pkg::NB_OPCODE]);
   assign valid = i_frame_from_host[debug_pkg::VALID_POS];
   assign req_type = debug_pkg::req_type_e'(
      i_frame_from_host[debug_pkg::NB_DATA +: debug_pkg::NB_REQ_TYPE]);
   assign data = i_frame_from_host[debug_pkg::NB_DATA-1:0];

   // a command acts once, on the rising edge of its valid bit
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         valid_d <= 1'b0;
      end else begin
         valid_d <= valid;
      end
   end

   assign strobe = valid & ~valid_d;

   // run and mode flags
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         run       <= 1'b0;
         step_mode <= 1'b0;
      end else if (strobe) begin
         if (opcode == debug_pkg::START) begin
            run <= 1'b1;
         end
         if (opcode == debug_pkg::MODE_SET_STEP) begin
            step_mode <= 1'b1;
         end else if (opcode == debug_pkg::MODE_SET_CONT) begin
            step_mode <= 1'b0;
         end
      end
   end

   assign cmd.strobe    = strobe;
   assign cmd.opcode    = opcode;
   assign cmd.step_mode = step_mode;

   // step mode only lets the core advance on a STEP command
   assign o_mips_valid = step_mode ? (strobe && opcode == debug_pkg::STEP && run) : run;
   assign o_mips_reset = strobe && opcode == debug_pkg::RESET;

   // instruction memory load, half word at a time
   always_comb begin
      o_instr_mem_we = debug_pkg::WE_NONE;
      if (strobe && opcode == debug_pkg::LOAD_INSTR_LSB) begin
         o_instr_mem_we = debug_pkg::WE_LSB;
      end else if (strobe && opcode == debug_pkg::LOAD_INSTR_MSB) begin
         o_instr_mem_we = debug_pkg::WE_MSB;
      end
   end

   assign o_instr_data = (opcode == debug_pkg::LOAD_INSTR_MSB) ?
                         {data, {debug_pkg::NB_DATA{1'b0}}} :
                         {{debug_pkg::NB_DATA{1'b0}}, data};
   assign o_instr_addr = {{(debug_pkg::NB_DATA-debug_pkg::NB_REQ_TYPE){1'b0}}, req_type};
   assign o_mem_addr   = data;

   // request type to select code
   always_comb begin
      case (req_type)
         debug_pkg::REQ_MEM_DATA:         type_select = debug_pkg::SEL_MEM_DATA;
         debug_pkg::REQ_MEM_INSTR:        type_select = debug_pkg::SEL_MEM_INSTR;
         debug_pkg::REQ_REG:              type_select = {1'b0, data[debug_pkg::NB_REG_NUM-1:0]};
         debug_pkg::REQ_REG_PC:           type_select = debug_pkg::SEL_PC;
         debug_pkg::REQ_LATCH_FETCH_DATA: type_select = debug_pkg::SEL_FETCH_DATA;
         debug_pkg::REQ_LATCH_FETCH_CTRL: type_select = debug_pkg::SEL_FETCH_CTRL;
         debug_pkg::REQ_LATCH_DECO_DATA:  type_select = debug_pkg::SEL_DECO_DATA;
         debug_pkg::REQ_LATCH_DECO_CTRL:  type_select = debug_pkg::SEL_DECO_CTRL;
         debug_pkg::REQ_LATCH_EXEC_DATA:  type_select = debug_pkg::SEL_EXEC_DATA;
         debug_pkg::REQ_LATCH_EXEC_CTRL:  type_select = debug_pkg::SEL_EXEC_CTRL;
         debug_pkg::REQ_LATCH_MEM_DATA:   type_select = debug_pkg::SEL_MEM_LATCH_DATA;
         debug_pkg::REQ_LATCH_MEM_CTRL:   type_select = debug_pkg::SEL_MEM_LATCH_CTRL;
         default:                         type_select = debug_pkg::SEL_NONE;
      endcase
   end

   assign o_request_select = (strobe && opcode == debug_pkg::REQ_DATA) ?
                             type_select : debug_pkg::SEL_NONE;

endmodule

`default_nettype wire

// ==== hw/debug_capture_buffer.sv ====
// core stream capture buffer
`default_nettype none

module debug_capture_buffer (
   input  wire                     i_clock,
   input  wire                     i_reset,
   input  wire debug_pkg::frame_t  i_frame_from_mips,
   input  wire                     i_eod,
   debug_cmd_if.sink               cmd,
   capture_if.source               cap
);

   debug_pkg::frame_t                  mem [debug_pkg::BUFFER_WORDS];
   logic [debug_pkg::NB_COUNT-1:0]     count;
   logic [debug_pkg::NB_COUNT-1:0]     rd_ptr;
   logic                               capturing;
   logic                               has_word;
   logic                               store;

   assign has_word = rd_ptr < count;
   assign store    = capturing && !i_eod;

   // capture control, restarted by every data request
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         capturing <= 1'b0;
         count     <= '0;
      end else if (cmd.strobe && cmd.opcode == debug_pkg::REQ_DATA) begin
         capturing <= 1'b1;
         count     <= '0;
      end else if (capturing) begin
         if (i_eod) begin
            capturing <= 1'b0;
         end else begin
            count <= count + 1'b1;
            // last free slot
            if (count == debug_pkg::NB_COUNT'(debug_pkg::BUFFER_WORDS - 1)) begin
               capturing <= 1'b0;
            end
         end
      end
   end

   // one stored word per cycle at the slot of the count
   always_ff @(posedge i_clock) begin
      if (store) begin
         mem[count] <= i_frame_from_mips;
      end
   end

   // read pointer toward the host
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         rd_ptr <= '0;
      end else if (cmd.strobe && cmd.opcode == debug_pkg::REQ_DATA) begin
         rd_ptr <= '0;
      end else if (cmd.strobe && cmd.opcode == debug_pkg::GIB_DATA && has_word) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   assign cap.word      = has_word ? mem[rd_ptr] : '0;
   assign cap.has_word  = has_word;
   assign cap.capturing = capturing;
   assign cap.count     = count;

   // the host never reads past the captured words
   a_read_in_count: assert property (@(posedge i_clock) disable iff (i_reset)
      rd_ptr <= count);

endmodule

`default_nettype wire

// ==== hw/debug_response_framer.sv ====
// host reply framer
`default_nettype none

module debug_response_framer (
   input  wire                  i_clock,
   input  wire                  i_reset,
   input  wire                  i_eop,
   debug_cmd_if.sink            cmd,
   capture_if.sink              cap,
   output debug_pkg::frame_t    o_frame_to_host
);

   debug_pkg::frame_t reply;

   // reply priority: data status, data word, mode, end of program
   always_comb begin
      if (cmd.opcode == debug_pkg::GOT_DATA) begin
         reply = cap.has_word ? debug_pkg::REPLY_OK : debug_pkg::REPLY_NOK;
      end else if (cmd.opcode == debug_pkg::GIB_DATA && cap.has_word) begin
         reply = cap.word;
      end else if (cmd.opcode == debug_pkg::MODE_GET) begin
         reply = cmd.step_mode ? debug_pkg::REPLY_MODE_STEP : debug_pkg::REPLY_MODE_CONT;
      end else if (i_eop) begin
         reply = debug_pkg::REPLY_EOP;
      end else begin
         reply = debug_pkg::REPLY_IDLE;
      end
   end

   // held between commands
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_frame_to_host <= '0;
      end else if (cmd.strobe) begin
         o_frame_to_host <= reply;
      end
   end

   // a running capture always has a free slot left
   a_capture_room: assert property (@(posedge i_clock) disable iff (i_reset)
      cap.capturing |-> cap.count < debug_pkg::NB_COUNT'(debug_pkg::BUFFER_WORDS));

endmodule

`default_nettype wire

// ==== hw/debug_unit.sv ====
// MIPS debug unit top level
`default_nettype none

module debug_unit (
   input  wire                                 i_clock,
   input  wire                                 i_reset,
   input  wire debug_pkg::frame_t              i_frame_from_host,
   input  wire debug_pkg::frame_t              i_frame_from_mips,
   input  wire                                 i_eod,
   input  wire                                 i_eop,
   output debug_pkg::frame_t                   o_frame_to_host,
   output logic                                o_mips_reset,
   output logic                                o_mips_valid,
   output logic [debug_pkg::NB_FRAME-1:0]      o_instr_data,
   output logic [debug_pkg::NB_DATA-1:0]       o_instr_addr,
   output debug_pkg::we_t                      o_instr_mem_we,
   output logic [debug_pkg::NB_DATA-1:0]       o_mem_addr,
   output debug_pkg::select_t                  o_request_select
);

   debug_cmd_if cmd_bus ();
   capture_if   cap_bus ();

   // host frames in, core controls out
   debug_command_decoder u_decoder (
      .i_clock           (i_clock),
      .i_reset           (i_reset),
      .i_frame_from_host (i_frame_from_host),
      .cmd               (cmd_bus.source),
      .o_mips_reset      (o_mips_reset),
      .o_mips_valid      (o_mips_valid),
      .o_instr_data      (o_instr_data),
      .o_instr_addr      (o_instr_addr),
      .o_instr_mem_we    (o_instr_mem_we),
      .o_mem_addr        (o_mem_addr),
      .o_request_select  (o_request_select)
   );

   // words streamed back by the core
   debug_capture_buffer u_buffer (
      .i_clock           (i_clock),
      .i_reset           (i_reset),
      .i_frame_from_mips (i_frame_from_mips),
      .i_eod             (i_eod),
      .cmd               (cmd_bus.sink),
      .cap               (cap_bus.source)
   );

   debug_response_framer u_framer (
      .i_clock           (i_clock),
      .i_reset           (i_reset),
      .i_eop             (i_eop),
      .cmd               (cmd_bus.sink),
      .cap               (cap_bus.sink),
      .o_frame_to_host   (o_frame_to_host)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// testbench clock and reset
`default_nettype none

module tb_clock_gen (
   output logic o_clock,
   output logic o_reset
);

   // period of 100
   initial begin
      o_clock = 1'b0;
      forever #50 o_clock = ~o_clock;
   end

   // reset held over five rising edges
   initial begin
      o_reset = 1'b1;
      repeat (5) @(posedge o_clock);
      #10;
      o_reset = 1'b0;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_debug_unit.sv ====
// debug unit testbench
`default_nettype none

module tb_debug_unit;

   // one row per clock cycle, expected values seen during that cycle
   typedef struct packed {
      debug_pkg::frame_t  host;
      debug_pkg::frame_t  mips;
      logic               eod;
      logic               eop;
      debug_pkg::frame_t  exp_reply;
      debug_pkg::select_t exp_select;
      debug_pkg::we_t     exp_we;
      logic               exp_valid;
      logic               exp_reset;
      logic               chk_instr;
      debug_pkg::frame_t  exp_instr;
      logic [15:0]        exp_addr;
      logic               chk_mem;
      logic [15:0]        exp_mem;
   } row_t;

   logic               clock;
   logic               reset;
   debug_pkg::frame_t  frame_from_host;
   debug_pkg::frame_t  frame_from_mips;
   debug_pkg::frame_t  frame_to_host;
   logic               eod;
   logic               eop;
   logic               mips_reset;
   logic               mips_valid;
   logic [31:0]        instr_data;
   logic [15:0]        instr_addr;
   logic [15:0]        mem_addr;
   debug_pkg::we_t     instr_mem_we;
   debug_pkg::select_t request_select;

   row_t               table_q[$];
   int                 errors = 0;
   int                 checks = 0;
   int                 row_idx = 0;
   int                 cycles = 0;
   int                 cycle_limit = 0;

   // expected state while the table is built
   logic               model_run;
   logic               model_step;
   logic               cur_eod;
   logic               cur_eop;
   debug_pkg::frame_t  held_reply;
   debug_pkg::frame_t  cur_mips;
   debug_pkg::frame_t  cur_host;
   logic [31:0]        rng_state;

   tb_clock_gen u_clock_gen (
      .o_clock (clock),
      .o_reset (reset)
   );

   debug_unit u_dut (
      .i_clock           (clock),
      .i_reset           (reset),
      .i_frame_from_host (frame_from_host),
      .i_frame_from_mips (frame_from_mips),
      .i_eod             (eod),
      .i_eop             (eop),
      .o_frame_to_host   (frame_to_host),
      .o_mips_reset      (mips_reset),
      .o_mips_valid      (mips_valid),
      .o_instr_data      (instr_data),
      .o_instr_addr      (instr_addr),
      .o_instr_mem_we    (instr_mem_we),
      .o_mem_addr        (mem_addr),
      .o_request_select  (request_select)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // opcode | valid | request type | data
   function automatic debug_pkg::frame_t make_frame(input debug_pkg::opcode_e op,
                                                    input logic [8:0] rtype,
                                                    input logic [15:0] data);
      return {op, 1'b1, rtype, data};
   endfunction

   task automatic add_row(input debug_pkg::frame_t host, input debug_pkg::select_t sel,
                          input debug_pkg::we_t we, input logic mv, input logic mr,
                          input logic ci, input debug_pkg::frame_t instr,
                          input logic [15:0] addr, input logic cm,
                          input logic [15:0] maddr);
      row_t r;
      r = '{host, cur_mips, cur_eod, cur_eop, held_reply, sel, we, mv, mr, ci, instr, addr,
            cm, maddr};
      table_q.push_back(r);
   endtask

   // valid low, no strobe
   task automatic hold_row();
      add_row(cur_host, debug_pkg::SEL_NONE, debug_pkg::WE_NONE, !model_step && model_run,
              1'b0, 1'b0, '0, '0, 1'b0, '0);
   endtask

   task automatic send_cmd(input debug_pkg::opcode_e op, input logic [8:0] rtype,
                           input logic [15:0] data, input debug_pkg::select_t sel,
                           input debug_pkg::we_t we, input debug_pkg::frame_t reply);
      debug_pkg::frame_t frame;
      debug_pkg::frame_t instr;
      logic              valid_exp;
      frame = make_frame(op, rtype, data);
      instr = (we == debug_pkg::WE_MSB) ? {data, 16'h0000} : {16'h0000, data};
      // step mode lets a STEP through only while running
      valid_exp = model_step ? (op == debug_pkg::STEP && model_run) : model_run;
      add_row(frame, sel, we, valid_exp, op == debug_pkg::RESET, we != debug_pkg::WE_NONE,
              instr, {7'd0, rtype}, op == debug_pkg::REQ_DATA, data);
      if (op == debug_pkg::START) begin
         model_run = 1'b1;
      end
      if (op == debug_pkg::MODE_SET_STEP) begin
         model_step = 1'b1;
      end else if (op == debug_pkg::MODE_SET_CONT) begin
         model_step = 1'b0;
      end
      held_reply = reply;
      cur_host = frame;
      cur_host[debug_pkg::VALID_POS] = 1'b0;
      hold_row();
   endtask

   task automatic send_plain(input debug_pkg::opcode_e op, input debug_pkg::frame_t reply);
      send_cmd(op, 9'd0, 16'd0, debug_pkg::SEL_NONE, debug_pkg::WE_NONE, reply);
   endtask

   // register number 19 rides in the data field
   task automatic send_request(input logic [8:0] rtype, input debug_pkg::select_t sel);
      send_cmd(debug_pkg::REQ_DATA, rtype, 16'd19, sel, debug_pkg::WE_NONE,
               debug_pkg::REPLY_IDLE);
   endtask

   task automatic build_table();
      debug_pkg::frame_t word0;
      debug_pkg::frame_t word1;
      rng_state  = 32'hc3d4_00e1;
      model_run  = 1'b0;
      model_step = 1'b0;
      cur_eod    = 1'b0;
      cur_eop    = 1'b0;
      held_reply = '0;
      cur_mips   = '0;
      cur_host   = '0;
      hold_row();
      hold_row();
      send_cmd(debug_pkg::LOAD_INSTR_LSB, 9'h012, 16'habcd, debug_pkg::SEL_NONE,
               debug_pkg::WE_LSB, debug_pkg::REPLY_IDLE);
      send_cmd(debug_pkg::LOAD_INSTR_MSB, 9'h013, 16'h1234, debug_pkg::SEL_NONE,
               debug_pkg::WE_MSB, debug_pkg::REPLY_IDLE);
      send_plain(debug_pkg::RESET, debug_pkg::REPLY_IDLE);
      // core ends each stream at once here
      cur_eod = 1'b1;
      send_request(debug_pkg::REQ_MEM_DATA, debug_pkg::SEL_MEM_DATA);
      send_request(debug_pkg::REQ_MEM_INSTR, debug_pkg::SEL_MEM_INSTR);
      send_request(debug_pkg::REQ_REG, 6'b010011);
      send_request(debug_pkg::REQ_REG_PC, debug_pkg::SEL_PC);
      send_request(debug_pkg::REQ_LATCH_FETCH_DATA, debug_pkg::SEL_FETCH_DATA);
      send_request(debug_pkg::REQ_LATCH_FETCH_CTRL, debug_pkg::SEL_FETCH_CTRL);
      send_request(debug_pkg::REQ_LATCH_DECO_DATA, debug_pkg::SEL_DECO_DATA);
      send_request(debug_pkg::REQ_LATCH_DECO_CTRL, debug_pkg::SEL_DECO_CTRL);
      send_request(debug_pkg::REQ_LATCH_EXEC_DATA, debug_pkg::SEL_EXEC_DATA);
      send_request(debug_pkg::REQ_LATCH_EXEC_CTRL, debug_pkg::SEL_EXEC_CTRL);
      send_request(debug_pkg::REQ_LATCH_MEM_DATA, debug_pkg::SEL_MEM_LATCH_DATA);
      send_request(debug_pkg::REQ_LATCH_MEM_CTRL, debug_pkg::SEL_MEM_LATCH_CTRL);
      send_request(9'h1ff, debug_pkg::SEL_NONE);
      cur_eod = 1'b0;
      // mode control, STEP before START must not pulse
      send_plain(debug_pkg::MODE_SET_STEP, debug_pkg::REPLY_IDLE);
      send_plain(debug_pkg::MODE_GET, debug_pkg::REPLY_MODE_STEP);
      send_plain(debug_pkg::STEP, debug_pkg::REPLY_IDLE);
      send_plain(debug_pkg::START, debug_pkg::REPLY_IDLE);
      hold_row();
      send_plain(debug_pkg::STEP, debug_pkg::REPLY_IDLE);
      send_plain(debug_pkg::STEP, debug_pkg::REPLY_IDLE);
      send_plain(debug_pkg::MODE_SET_CONT, debug_pkg::REPLY_IDLE);
      hold_row();
      hold_row();
      send_plain(debug_pkg::MODE_GET, debug_pkg::REPLY_MODE_CONT);
      // two streamed words, then end of data
      rng_state = xorshift32(rng_state);
      word0 = rng_state;
      rng_state = xorshift32(rng_state);
      word1 = rng_state;
      cur_mips = word0;
      send_cmd(debug_pkg::REQ_DATA, debug_pkg::REQ_MEM_DATA, 16'h0040, debug_pkg::SEL_MEM_DATA,
               debug_pkg::WE_NONE, debug_pkg::REPLY_IDLE);
      cur_mips = word1;
      hold_row();
      rng_state = xorshift32(rng_state);
      cur_mips = rng_state;
      cur_eod = 1'b1;
      hold_row();
      cur_eod = 1'b0;
      send_plain(debug_pkg::GOT_DATA, debug_pkg::REPLY_OK);
      send_plain(debug_pkg::GIB_DATA, word0);
      send_plain(debug_pkg::GIB_DATA, word1);
      send_plain(debug_pkg::GIB_DATA, debug_pkg::REPLY_IDLE);
      send_plain(debug_pkg::GOT_DATA, debug_pkg::REPLY_NOK);
      cur_eop = 1'b1;
      send_plain(debug_pkg::STEP, debug_pkg::REPLY_EOP);
      cur_eop = 1'b0;
      hold_row();
   endtask

   task automatic check_frame(input string name, input debug_pkg::frame_t got,
                              input debug_pkg::frame_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s: got %h expected %h", row_idx, name, got, exp);
      end
   endtask

   task automatic check_select(input string name, input debug_pkg::select_t got,
                               input debug_pkg::select_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s: got %h expected %h", row_idx, name, got, exp);
      end
   endtask

   task automatic check_we(input string name, input debug_pkg::we_t got,
                           input debug_pkg::we_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s: got %h expected %h", row_idx, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s: got %h expected %h", row_idx, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] row %0d %s: got %h expected %h", row_idx, name, got, exp);
      end
   endtask

   task automatic check_row(input row_t r);
      check_frame("o_frame_to_host", frame_to_host, r.exp_reply);
      check_select("o_request_select", request_select, r.exp_select);
      check_we("o_instr_mem_we", instr_mem_we, r.exp_we);
      check_bit("o_mips_valid", mips_valid, r.exp_valid);
      check_bit("o_mips_reset", mips_reset, r.exp_reset);
      if (r.chk_instr) begin
         check_frame("o_instr_data", instr_data, r.exp_instr);
         check_addr("o_instr_addr", instr_addr, r.exp_addr);
      end
      // data requests carry the memory address in the data field
      if (r.chk_mem) begin
         check_addr("o_mem_addr", mem_addr, r.exp_mem);
      end
   endtask

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: table not finished after %0d cycles", cycle_limit);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      frame_from_host = '0;
      frame_from_mips = '0;
      eod = 1'b0;
      eop = 1'b0;
      build_table();
      cycle_limit = 2 * table_q.size() + 20;
      @(negedge reset);
      // inputs change 10 after the edge, outputs sampled mid cycle
      for (row_idx = 0; row_idx < table_q.size(); row_idx++) begin
         frame_from_host = table_q[row_idx].host;
         frame_from_mips = table_q[row_idx].mips;
         eod = table_q[row_idx].eod;
         eop = table_q[row_idx].eop;
         #40;
         check_row(table_q[row_idx]);
         @(posedge clock);
         #10;
      end
      $display("rows: %0d, checks: %0d, errors: %0d", table_q.size(), checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== debug_unit.f ====
hw/debug_pkg.sv
hw/debug_if.sv
hw/debug_command_decoder.sv
hw/debug_capture_buffer.sv
hw/debug_response_framer.sv
hw/debug_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_debug_unit.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_debug_unit -f debug_unit.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_debug_unit \
		-f debug_unit.f -Mdir obj_dir
	./obj_dir/Vtb_debug_unit | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
